/* carry_resolver.f */
+incdir+.
carry_pkg.sv
pending_if.sv
carry_ctrl.sv
pending_buffer.sv
release_packer.sv
carry_resolver.sv
tb_carry_resolver.sv

/* Makefile */
# Carry resolver simulation with Verilator

VERILATOR ?= verilator
TOP ?= tb_carry_resolver
FILELIST ?= carry_resolver.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= Test failed
PASS_MSG ?= Test passed
VFLAGS ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/10ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_carry_tasks.svh */
/*
 * Carry resolver test tasks
 * Token drive, stream compare and the directed and random tests
 */

`ifndef TB_CARRY_TASKS_SVH
`define TB_CARRY_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        fail_count++;
        $display("FAIL %s: got %h, expected %h", name, got, exp);
        $display("Test failed");
        $fatal(1, "mismatch on %s", name);
    end
endtask

task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    in_valid <= 1'b0;
    flush <= 1'b0;
    repeat (2) @(posedge clk);
    // Output register is cleared by the first reset edge
    check_value("out_count", 32'(out_count), 0);
    @(posedge clk);
    model_q.delete();
    got_q.delete();
    release_cycles = 0;
    run_len = 0;
    reset <= 1'b0;
endtask

// Called only while the output is drained
task automatic start_stream();
    model_q.delete();
    got_q.delete();
    release_cycles = 0;
endtask

task automatic send_token(input byte_t value, input bit carry);
    @(posedge clk);
    in_valid <= 1'b1;
    in_token <= token_t'({carry, value});
    flush <= 1'b0;
    model_token(value, carry);
    // A carry or a byte below 255 starts a new run
    if (carry || (value != 8'hff)) begin
        run_len = 1;
        run_head = value;
    end else begin
        if (run_len == 0) begin
            run_head = value;
        end
        run_len++;
    end
endtask

task automatic idle(input int cycles);
    repeat (cycles) begin
        @(posedge clk);
        in_valid <= 1'b0;
        flush <= 1'b0;
    end
endtask

// Flush, then wait for every model byte and an empty output
task automatic end_stream();
    @(posedge clk);
    in_valid <= 1'b0;
    flush <= 1'b1;
    run_len = 0;
    @(posedge clk);
    flush <= 1'b0;
    while (got_q.size() < model_q.size()) begin
        @(posedge clk);
    end
    do begin
        @(posedge clk);
    end while (out_count != '0);
endtask

task automatic compare_stream();
    for (int i = 0; i < model_q.size(); i++) begin
        check_value($sformatf("out_byte[%0d]", i), 32'(got_q[i]), 32'(model_q[i]));
    end
    check_value("byte total", got_q.size(), model_q.size());
endtask

task automatic plain_bytes_test();
    start_stream();
    for (int i = 0; i < PLAIN_LEN; i++) begin
        send_token(byte_t'(8'h20 + 8'(i * 7)), 1'b0);
    end
    idle(4);
    // Last byte is the run head and stays back
    check_value("held byte count", got_q.size(), PLAIN_LEN - 1);
    end_stream();
    compare_stream();
endtask

task automatic max_run_test();
    start_stream();
    for (int i = 0; i < RUN_LEN - 1; i++) begin
        send_token(8'hff, 1'b0);
    end
    send_token(8'h42, 1'b0);
    end_stream();
    compare_stream();
endtask

task automatic carry_run_test();
    start_stream();
    send_token(8'h7e, 1'b0);
    for (int i = 0; i < CARRY_LEN - 2; i++) begin
        send_token(8'hff, 1'b0);
    end
    send_token(8'h13, 1'b1);
    end_stream();
    compare_stream();
endtask

task automatic long_flush_test();
    start_stream();
    send_token(8'h90, 1'b0);
    for (int i = 0; i < LONG_LEN - 1; i++) begin
        send_token(8'hff, 1'b0);
    end
    end_stream();
    compare_stream();
    // Whole run went out in full releases
    check_value("release cycles", release_cycles, LONG_LEN / `CR_OUT_LANES);
endtask

task automatic random_stream_test();
    byte_t value;
    bit carry;
    start_stream();
    for (int i = 0; i < RANDOM_LEN; i++) begin
        if ($urandom_range(0, 2) == 0) begin
            value = 8'hff;
        end else begin
            value = byte_t'($urandom);
        end
        // Keep runs well inside the buffer
        if ((run_len >= 8) && (value == 8'hff)) begin
            value = 8'hfe;
        end
        carry = (run_len > 0) && (run_head != 8'hff) && ($urandom_range(0, 3) == 0);
        send_token(value, carry);
        if ($urandom_range(0, 7) == 0) begin
            idle(1);
        end
    end
    end_stream();
    compare_stream();
endtask

task automatic reset_restart_test();
    start_stream();
    for (int i = 0; i < RESTART_LEN / 2; i++) begin
        send_token(byte_t'($urandom), 1'b0);
    end
    apply_reset();
    start_stream();
    send_token(8'h55, 1'b0);
    send_token(8'hff, 1'b0);
    send_token(8'hff, 1'b0);
    send_token(8'h10, 1'b1);
    for (int i = 0; i < RESTART_LEN / 2 - 4; i++) begin
        send_token(byte_t'($urandom), 1'b0);
    end
    end_stream();
    compare_stream();
endtask

`endif

/* tb_carry_resolver.sv */
/*
 * Carry resolver testbench
 * Directed and random token streams checked against a byte queue model
 */

`timescale 1ns/10ps

`include "carry_resolver_config.svh"

module tb_carry_resolver;
    import carry_pkg::*;

    // Test lengths in tokens
    localparam int PLAIN_LEN = 8;
    localparam int RUN_LEN = 6;
    localparam int CARRY_LEN = 6;
    localparam int LONG_LEN = 12;
    localparam int RANDOM_LEN = 400;
    localparam int RESTART_LEN = 40;
    // Reset, flush and drain cycles per test
    localparam int DRAIN_MARGIN = 40;
    // Random stream may idle, so it counts twice
    localparam int CYCLE_LIMIT = PLAIN_LEN + RUN_LEN + CARRY_LEN + LONG_LEN
        + 2 * RANDOM_LEN + RESTART_LEN + 7 * DRAIN_MARGIN;

    logic clk;
    logic reset;
    logic in_valid;
    token_t in_token;
    logic flush;
    byte_t out_byte_0;
    byte_t out_byte_1;
    byte_t out_byte_2;
    byte_t out_byte_3;
    lane_count_t out_count;

    byte_t out_lanes [`CR_OUT_LANES];
    byte_t model_q [$];
    byte_t got_q [$];
    int release_cycles = 0;
    int cycle_count = 0;
    int fail_count = 0;

    // Pending run as the coder sees it
    int run_len = 0;
    byte_t run_head = '0;

    // ==============================
    // Clock and DUT
    // ==============================
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    carry_resolver i_carry_resolver (
        .clk (clk),
        .reset (reset),
        .in_valid (in_valid),
        .in_token (in_token),
        .flush (flush),
        .out_byte_0 (out_byte_0),
        .out_byte_1 (out_byte_1),
        .out_byte_2 (out_byte_2),
        .out_byte_3 (out_byte_3),
        .out_count (out_count)
    );

    assign out_lanes[0] = out_byte_0;
    assign out_lanes[1] = out_byte_1;
    assign out_lanes[2] = out_byte_2;
    assign out_lanes[3] = out_byte_3;

    // ==============================
    // Reference model
    // ==============================
    // Carry goes into the bytes already out, then the new byte is appended
    function automatic void model_token(input byte_t value, input bit carry);
        int idx;
        if (carry) begin
            idx = model_q.size() - 1;
            while (model_q[idx] == 8'hff) begin
                model_q[idx] = 8'h00;
                idx--;
            end
            model_q[idx] = model_q[idx] + 8'h01;
        end
        model_q.push_back(value);
    endfunction

    `include "tb_carry_tasks.svh"

    // ==============================
    // Output monitor and timeout
    // ==============================
    always @(posedge clk) begin
        if (out_count > lane_count_t'(`CR_OUT_LANES)) begin
            check_value("out_count", 32'(out_count), `CR_OUT_LANES);
        end
        if (out_count != '0) begin
            release_cycles++;
        end
        for (int i = 0; i < `CR_OUT_LANES; i++) begin
            if (i < int'(out_count)) begin
                got_q.push_back(out_lanes[i]);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: output still incomplete after %0d cycles", cycle_count);
            $display("Test failed");
            $fatal(1, "simulation timed out");
        end
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_token = '0;
        flush = 1'b0;
        void'($urandom(32'h7f89));
        apply_reset();
        plain_bytes_test();
        max_run_test();
        carry_run_test();
        long_flush_test();
        random_stream_test();
        reset_restart_test();
        if (fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* carry_resolver.sv */
/*
 * Carry resolver top level
 * One coder token in per cycle, up to four final bytes out per cycle
 */

`timescale 1ns/10ps

module carry_resolver (
    input logic clk,
    input logic reset,
    input logic in_valid,
    input carry_pkg::token_t in_token,
    input logic flush,
    output carry_pkg::byte_t out_byte_0,
    output carry_pkg::byte_t out_byte_1,
    output carry_pkg::byte_t out_byte_2,
    output carry_pkg::byte_t out_byte_3,
    output carry_pkg::lane_count_t out_count
);
    import carry_pkg::*;

    pending_if pend ();

    buf_addr_t commit_ptr;
    buf_addr_t rd_ptr;
    byte_lanes_t rd_data;
    byte_lanes_t out_bytes;

    carry_ctrl i_carry_ctrl (
        .clk (clk),
        .reset (reset),
        .in_valid (in_valid),
        .in_token (in_token),
        .flush (flush),
        .rd_ptr (rd_ptr),
        .commit_ptr (commit_ptr),
        .pend (pend.ctrl)
    );

    pending_buffer i_pending_buffer (
        .clk (clk),
        .pend (pend.store),
        .rd_ptr (rd_ptr),
        .rd_data (rd_data)
    );

    release_packer i_release_packer (
        .clk (clk),
        .reset (reset),
        .commit_ptr (commit_ptr),
        .rd_data (rd_data),
        .rd_ptr (rd_ptr),
        .out_bytes (out_bytes),
        .out_count (out_count)
    );

    // Lane 0 is the oldest byte of the release
    assign out_byte_0 = out_bytes[0];
    assign out_byte_1 = out_bytes[1];
    assign out_byte_2 = out_bytes[2];
    assign out_byte_3 = out_bytes[3];

endmodule

/* release_packer.sv */
/*
 * Release packer
 * Drains up to four final bytes per cycle in order and registers
 * them with their count
 */

`timescale 1ns/10ps

module release_packer (
    input logic clk,
    input logic reset,
    input carry_pkg::buf_addr_t commit_ptr,
    input carry_pkg::byte_lanes_t rd_data,
    output carry_pkg::buf_addr_t rd_ptr,
    output carry_pkg::byte_lanes_t out_bytes,
    output carry_pkg::lane_count_t out_count
);
    import carry_pkg::*;

    // Oldest byte not yet released
    buf_addr_t rd_q;
    // Final bytes waiting in the buffer
    buf_addr_t avail;
    lane_count_t take_count;

    // ==============================
    // Release count
    // ==============================
    assign avail = commit_ptr - rd_q;

    always_comb begin
        if (avail >= buf_addr_t'(`CR_OUT_LANES)) begin
            take_count = lane_count_t'(`CR_OUT_LANES);
        end else begin
            take_count = lane_count_t'(avail);
        end
    end

    // ==============================
    // Read pointer and count
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q <= '0;
            out_count <= '0;
        end else begin
            rd_q <= rd_q + buf_addr_t'(take_count);
            out_count <= take_count;
        end
    end

    // Lanes keep their old value on idle cycles
    always_ff @(posedge clk) begin
        if (take_count != '0) begin
            out_bytes <= rd_data;
        end
    end

    assign rd_ptr = rd_q;

endmodule

/* pending_buffer.sv */
/*
 * Pending byte buffer
 * Circular byte store with single writes, a one-cycle increment of the
 * pending run and four combinational read lanes
 */

`timescale 1ns/10ps

module pending_buffer (
    input logic clk,
    pending_if.store pend,
    input carry_pkg::buf_addr_t rd_ptr,
    output carry_pkg::byte_lanes_t rd_data
);
    import carry_pkg::*;

    byte_t mem [BUF_DEPTH];

    buf_addr_t run_len;
    // Per entry flags for the pending run
    logic [BUF_DEPTH-1:0] in_run;
    logic [BUF_DEPTH-1:0] past_head;
    logic [BUF_DEPTH-1:0] is_max;

    assign run_len = pend.run_hi - pend.run_lo;

    // ==============================
    // Run membership
    // ==============================
    for (genvar g = 0; g < BUF_DEPTH; g++) begin : g_entry
        buf_addr_t offs;

        // Distance from the run head, modulo the depth
        assign offs = buf_addr_t'(g) - pend.run_lo;
        assign in_run[g] = (offs < run_len);
        assign past_head[g] = in_run[g] && (offs != '0);
        assign is_max[g] = (mem[g] == BYTE_MAX);
    end

    // ==============================
    // Storage
    // ==============================
    always_ff @(posedge clk) begin
        // Carry into the run, head goes up by one and the 255s wrap to 0
        for (int i = 0; i < BUF_DEPTH; i++) begin
            if (pend.inc_en && in_run[i]) begin
                if (past_head[i]) begin
                    mem[i] <= '0;
                end else begin
                    mem[i] <= mem[i] + byte_t'(1);
                end
            end
        end

        // New byte lands at run_hi, just outside the run
        if (pend.wr_en) begin
            mem[pend.wr_addr] <= pend.wr_data;
        end
    end

    // ==============================
    // Reads
    // ==============================
    assign pend.head_byte = mem[pend.run_lo];

    for (genvar k = 0; k < `CR_OUT_LANES; k++) begin : g_lane
        assign rd_data[k] = mem[buf_addr_t'(rd_ptr + buf_addr_t'(k))];
    end

    // Only 255 bytes may follow the head, otherwise the run was cut wrong
    a_run_all_max: assert property (
        @(posedge clk)
        pend.inc_en |-> ((is_max | ~past_head) == '1)
    ) else $error("non-255 byte behind head of pending run");

endmodule

/* carry_ctrl.sv */
/*
 * Carry controller
 * Splits each token into byte and carry, owns the write and commit
 * pointers and decides when the pending run is incremented
 */

`timescale 1ns/10ps

module carry_ctrl (
    input logic clk,
    input logic reset,
    input logic in_valid,
    input carry_pkg::token_t in_token,
    input logic flush,
    input carry_pkg::buf_addr_t rd_ptr,
    output carry_pkg::buf_addr_t commit_ptr,
    pending_if.ctrl pend
);
    import carry_pkg::*;

    byte_t tok_byte;
    carry_t tok_carry;
    logic has_carry;
    logic run_empty;

    // Next free entry, one past the pending run
    buf_addr_t wr_ptr;
    // First entry of the pending run, everything below it is final
    buf_addr_t commit_q;

    // ==============================
    // Token split
    // ==============================
    assign tok_byte = in_token[`CR_BYTE_WIDTH-1:0];
    assign tok_carry = in_token[`CR_TOKEN_WIDTH-1:`CR_BYTE_WIDTH];
    assign has_carry = in_valid && (tok_carry != '0);
    assign run_empty = (commit_q == wr_ptr);

    // ==============================
    // Pointers
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            commit_q <= '0;
        end else if (in_valid) begin
            wr_ptr <= wr_ptr + buf_addr_t'(1);
            // A carry resolves the old run, a byte below 255 starts a new one
            if (has_carry || (tok_byte != BYTE_MAX)) begin
                commit_q <= wr_ptr;
            end
        end else if (flush) begin
            // End of stream, the run goes out unchanged
            commit_q <= wr_ptr;
        end
    end

    // ==============================
    // Buffer requests
    // ==============================
    assign pend.wr_en = in_valid;
    assign pend.wr_addr = wr_ptr;
    assign pend.wr_data = tok_byte;

    // Increment covers the run as it stands before this token
    assign pend.inc_en = has_carry;
    assign pend.run_lo = commit_q;
    assign pend.run_hi = wr_ptr;

    assign commit_ptr = commit_q;

    // ==============================
    // Coder contract
    // ==============================
    // At most one carry per token
    a_carry_max_one: assert property (
        @(posedge clk) disable iff (reset)
        in_valid |-> (tok_carry <= carry_t'(1))
    ) else $error("carry above one in token %h", in_token);

    // Carry needs a run to land on, and its head must have room
    a_carry_target: assert property (
        @(posedge clk) disable iff (reset)
        has_carry |-> (!run_empty && (pend.head_byte != BYTE_MAX))
    ) else $error("carry into empty run or 255 head byte");

    // Write must stay clear of bytes not yet released
    a_no_overrun: assert property (
        @(posedge clk) disable iff (reset)
        in_valid |-> (buf_addr_t'(wr_ptr + buf_addr_t'(1)) != rd_ptr)
    ) else $error("pending buffer overrun at %h", wr_ptr);

endmodule

/* pending_if.sv */
/*
 * Pending run interface
 * Write, run increment and head byte between the carry controller
 * and the pending byte buffer
 */

`timescale 1ns/10ps

interface pending_if;
    import carry_pkg::*;

    // Single byte write
    logic wr_en;
    buf_addr_t wr_addr;
    byte_t wr_data;

    // Run increment over [run_lo, run_hi)
    logic inc_en;
    buf_addr_t run_lo;
    buf_addr_t run_hi;

    // Entry at run_lo
    byte_t head_byte;

    modport ctrl (
        output wr_en, wr_addr, wr_data,
        output inc_en, run_lo, run_hi,
        input head_byte
    );

    modport store (
        input wr_en, wr_addr, wr_data,
        input inc_en, run_lo, run_hi,
        output head_byte
    );

endinterface

/* carry_pkg.sv */
/*
 * Carry resolver types
 * Token, byte, pointer and lane types built from the config macros
 */

`include "carry_resolver_config.svh"

package carry_pkg;

    // ==============================
    // Sizes
    // ==============================
    localparam int BUF_DEPTH = 1 << `CR_BUF_ADDR_WIDTH;
    localparam int LANE_COUNT_WIDTH = $clog2(`CR_OUT_LANES + 1);

    // ==============================
    // Types
    // ==============================
    typedef logic [`CR_TOKEN_WIDTH-1:0] token_t;
    typedef logic [`CR_BYTE_WIDTH-1:0] byte_t;

    // Carry part of a token
    typedef logic [`CR_TOKEN_WIDTH-`CR_BYTE_WIDTH-1:0] carry_t;

    // Pointers wrap modulo the buffer depth
    typedef logic [`CR_BUF_ADDR_WIDTH-1:0] buf_addr_t;

    // Release count, 0 up to the lane count
    typedef logic [LANE_COUNT_WIDTH-1:0] lane_count_t;

    // Lane 0 holds the oldest byte
    typedef byte_t [`CR_OUT_LANES-1:0] byte_lanes_t;

    // A byte that a later carry would wrap to zero
    localparam byte_t BYTE_MAX = '1;

endpackage

/* carry_resolver_config.svh */
/*
 * Carry resolver sizes
 * Token, byte and buffer widths and the release width shared by the
 * carry resolver RTL and its testbench
 */

`ifndef CARRY_RESOLVER_CONFIG_SVH
`define CARRY_RESOLVER_CONFIG_SVH

// Coder token, output byte in the low bits and carry above it
`define CR_TOKEN_WIDTH 16

// Output byte
`define CR_BYTE_WIDTH 8

// Pending buffer address width, 16 entries
`define CR_BUF_ADDR_WIDTH 4

// Most bytes released in one cycle
`define CR_OUT_LANES 4

`endif
